//--- tb.f
+incdir+tests
logic/net_pkg.sv
logic/tx_source_if.sv
logic/arp_reply_builder.sv
logic/udp_ip_builder.sv
logic/frame_mux.sv
logic/net_tx_top.sv
tests/net_tx_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the transmit testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f tb.f --top-module net_tx_tb \
  && ./obj_dir/Vnet_tx_tb | tee /dev/stderr | grep -F '** PASS **' > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tests/net_tx_checks.svh
/* testbench helpers: lfsr, compare tasks, timed waits
   and the builders for the expected frames */

`ifndef NET_TX_CHECKS_SVH
`define NET_TX_CHECKS_SVH

// ------------------------------
// random source
// ------------------------------
// fibonacci lfsr, taps 32 22 2 1
function automatic logic lfsr_step();
  logic fb;
  fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
  lfsr = {lfsr[30:0], fb};
  return fb;
endfunction

// one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_step()};
  end
  return v;
endfunction

// ------------------------------
// compare tasks
// ------------------------------
task automatic check_byte(input string name, input byte_t got, input byte_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("[FAIL] t=%0t %s got 0x%02h expected 0x%02h",
                            $time, name, got, exp));
  end
endtask

task automatic check_len(input string name, input pay_len_t got, input pay_len_t exp);
  if (got !== exp) begin
    stop_on_error($sformatf("[FAIL] t=%0t %s got %0d expected %0d",
                            $time, name, got, exp));
  end
endtask

// ------------------------------
// timed waits
// ------------------------------
// until the capture holds target finished frames
task automatic wait_frames(input int target, input int limit);
  int cycles;
  cycles = 0;
  while (len_q.size() < target && cycles < limit) begin
    @(posedge tx_clock);
    cycles++;
  end
  if (len_q.size() < target) begin
    stop_on_error("timeout: the expected frames never finished on frame_valid");
  end
endtask

// until udp_tx_enable has pulsed target times in all
task automatic wait_enable(input int target, input int limit);
  int cycles;
  cycles = 0;
  while (enable_count < target && cycles < limit) begin
    @(posedge tx_clock);
    cycles++;
  end
  if (enable_count < target) begin
    stop_on_error("timeout: udp_tx_enable never pulsed after the udp request");
  end
endtask

// ------------------------------
// expected frames
// ------------------------------
// most significant byte first
function automatic void push_be(input logic [63:0] val, input int nbytes);
  for (int i = nbytes - 1; i >= 0; i--) begin
    exp_q.push_back(val[i*8 +: 8]);
  end
endfunction

function automatic void build_eth_header(input mac_addr_t dst, input logic [15:0] etype);
  push_be(64'(dst), 6);
  push_be(64'(local_mac), 6);
  push_be(64'(etype), 2);
endfunction

function automatic void build_arp_reply(input mac_addr_t qmac, input ip_addr_t qip);
  build_eth_header(qmac, 16'h0806);
  // ethernet hw, ipv4, lengths 6 and 4, reply
  push_be(64'h0001, 2);
  push_be(64'h0800, 2);
  push_be(64'h0604, 2);
  push_be(64'h0002, 2);
  push_be(64'(local_mac), 6);
  push_be(64'(local_ip), 4);
  push_be(64'(qmac), 6);
  push_be(64'(qip), 4);
  exp_lens.push_back(42);
endfunction

function automatic void build_udp_frame(input mac_addr_t dmac, input ip_addr_t dip,
                                        input udp_port_t dport);
  int ip_start;
  int len;
  int sum;
  len = pay_q.size();
  build_eth_header(dmac, 16'h0800);
  ip_start = exp_q.size();
  push_be(64'h4500, 2);
  push_be(64'(len + 28), 2);
  // id and flags/fragment
  push_be(64'h0, 4);
  // ttl 128, protocol 17
  push_be(64'h8011, 2);
  // checksum slot, zero while summing
  push_be(64'h0, 2);
  push_be(64'(local_ip), 4);
  push_be(64'(dip), 4);
  // ones complement sum of the ten header words
  sum = 0;
  for (int w = 0; w < 10; w++) begin
    sum = sum + int'({exp_q[ip_start + 2*w], exp_q[ip_start + 2*w + 1]});
  end
  while (sum > 32'hffff) begin
    sum = (sum & 32'hffff) + (sum >> 16);
  end
  exp_q[ip_start + 10] = ~sum[15:8];
  exp_q[ip_start + 11] = ~sum[7:0];
  // udp header, checksum unused
  push_be(64'd1024, 2);
  push_be(64'(dport), 2);
  push_be(64'(len + 8), 2);
  push_be(64'h0, 2);
  foreach (pay_q[i]) begin
    exp_q.push_back(pay_q[i]);
  end
  exp_lens.push_back(len + 42);
endfunction

`endif

//--- tests/net_tx_tb.sv
/* testbench for the ethernet transmit top level
   clock, reset, frame capture, payload feeder and directed tests */

`timescale 1ns/1ps

module net_tx_tb
  import net_pkg::*;
();

  localparam logic [31:0] LFSR_SEED      = 32'hd352;
  localparam int          FRAME_TIMEOUT  = 500;
  localparam int          ENABLE_TIMEOUT = 200;
  localparam int          RANDOM_FRAMES  = 6;

  // dut ports
  logic      tx_clock = 1'b0;
  logic      rst_n;
  mac_addr_t local_mac;
  ip_addr_t  local_ip;
  logic      arp_query;
  mac_addr_t query_mac;
  ip_addr_t  query_ip;
  logic      udp_tx_request;
  pay_len_t  udp_tx_length;
  mac_addr_t udp_dest_mac;
  ip_addr_t  udp_dest_ip;
  udp_port_t udp_dest_port;
  byte_t     udp_tx_data = 8'h00;
  logic      udp_tx_enable;
  logic      frame_valid;
  byte_t     frame_data;

  // capture and payload state
  logic [31:0] lfsr = LFSR_SEED;
  byte_t cap_q[$];
  int    len_q[$];
  int    run_len = 0;
  int    enable_count = 0;
  logic  enable_seen = 1'b0;
  logic  feeding = 1'b0;
  int    feed_idx = 0;
  byte_t pay_q[$];
  byte_t exp_q[$];
  int    exp_lens[$];
  int    cap_mark;
  int    len_mark;
  int    enable_mark;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  `include "net_tx_checks.svh"

  always #50 tx_clock = ~tx_clock;

  net_tx_top dut_i (.*);

  // ------------------------------
  // monitor at mid cycle
  // ------------------------------
  // one run of frame_valid is one frame
  always @(negedge tx_clock) begin
    if (frame_valid === 1'b1) begin
      cap_q.push_back(frame_data);
      run_len++;
    end else if (run_len != 0) begin
      len_q.push_back(run_len);
      run_len = 0;
    end
    if (udp_tx_enable === 1'b1) begin
      enable_count++;
    end
    enable_seen = (udp_tx_enable === 1'b1);
  end

  // payload byte k on the k+1-th cycle after the pulse
  always @(posedge tx_clock) begin
    #1;
    if (enable_seen) begin
      feeding = 1'b1;
      feed_idx = 0;
    end
    if (feeding) begin
      if (feed_idx < pay_q.size()) begin
        udp_tx_data = pay_q[feed_idx];
        feed_idx++;
      end else begin
        feeding = 1'b0;
        udp_tx_data = 8'h00;
      end
    end
  end

  // ------------------------------
  // test helpers
  // ------------------------------
  task automatic start_capture();
    cap_mark = cap_q.size();
    len_mark = len_q.size();
    enable_mark = enable_count;
    exp_q.delete();
    exp_lens.delete();
  endtask

  task automatic check_capture();
    wait_frames(len_mark + exp_lens.size(), FRAME_TIMEOUT);
    for (int f = 0; f < exp_lens.size(); f++) begin
      check_len("frame length", pay_len_t'(len_q[len_mark + f]), pay_len_t'(exp_lens[f]));
    end
    for (int i = 0; i < exp_q.size(); i++) begin
      check_byte($sformatf("frame_data[%0d]", i), cap_q[cap_mark + i], exp_q[i]);
    end
  endtask

  // drives the udp fields and raises the request
  task automatic prepare_udp(input int len, input mac_addr_t dmac, input ip_addr_t dip,
                             input udp_port_t dport, input logic random_payload);
    pay_q.delete();
    for (int i = 0; i < len; i++) begin
      if (random_payload) begin
        pay_q.push_back(byte_t'(rand_bits(8)));
      end else begin
        pay_q.push_back(8'hc0 + byte_t'(i));
      end
    end
    udp_tx_length = pay_len_t'(len);
    udp_dest_mac = dmac;
    udp_dest_ip = dip;
    udp_dest_port = dport;
    udp_tx_request = 1'b1;
    build_udp_frame(dmac, dip, dport);
  endtask

  // request held until the enable pulse
  task automatic release_udp_request();
    wait_enable(enable_mark + 1, ENABLE_TIMEOUT);
    #1;
    udp_tx_request = 1'b0;
  endtask

  // exactly one payload grant per udp frame
  task automatic check_single_enable();
    check_len("udp_tx_enable pulses", pay_len_t'(enable_count - enable_mark), 16'd1);
  endtask

  // ------------------------------
  // directed tests
  // ------------------------------
  task automatic test_idle();
    start_capture();
    repeat (20) @(posedge tx_clock);
    check_len("frame_valid cycles", pay_len_t'(cap_q.size() - cap_mark), 16'd0);
    check_len("udp_tx_enable pulses", pay_len_t'(enable_count - enable_mark), 16'd0);
  endtask

  task automatic test_arp_reply();
    start_capture();
    build_arp_reply(48'h00_1b_21_3a_4c_5e, 32'hc0a8_0a07);
    @(posedge tx_clock);
    #1;
    arp_query = 1'b1;
    query_mac = 48'h00_1b_21_3a_4c_5e;
    query_ip = 32'hc0a8_0a07;
    @(posedge tx_clock);
    #1;
    arp_query = 1'b0;
    check_capture();
  endtask

  task automatic test_udp_fixed();
    start_capture();
    @(posedge tx_clock);
    #1;
    prepare_udp(4, 48'h00_0e_c6_88_12_34, 32'hc0a8_0a64, 16'd5000, 1'b0);
    release_udp_request();
    check_capture();
    check_single_enable();
  endtask

  task automatic test_udp_random();
    int len;
    for (int n = 0; n < RANDOM_FRAMES; n++) begin
      start_capture();
      len = int'(rand_bits(6)) + 1;
      @(posedge tx_clock);
      #1;
      prepare_udp(len, 48'h00_0e_c6_88_12_34, rand_bits(32), udp_port_t'(rand_bits(16)),
                  1'b1);
      release_udp_request();
      check_capture();
      check_single_enable();
    end
  endtask

  // arp query and udp request in one cycle
  task automatic test_arp_and_udp();
    start_capture();
    build_arp_reply(48'h00_50_56_c0_00_08, 32'hc0a8_0a33);
    @(posedge tx_clock);
    #1;
    prepare_udp(9, 48'h00_0e_c6_88_12_34, 32'hc0a8_0a64, 16'd6001, 1'b1);
    arp_query = 1'b1;
    query_mac = 48'h00_50_56_c0_00_08;
    query_ip = 32'hc0a8_0a33;
    @(posedge tx_clock);
    #1;
    arp_query = 1'b0;
    release_udp_request();
    check_capture();
    check_single_enable();
  endtask

  initial begin
    rst_n = 1'b0;
    local_mac = 48'h02_00_5e_a1_b2_c3;
    local_ip = 32'hc0a8_0a02;
    arp_query = 1'b0;
    query_mac = '0;
    query_ip = '0;
    udp_tx_request = 1'b0;
    udp_tx_length = '0;
    udp_dest_mac = '0;
    udp_dest_ip = '0;
    udp_dest_port = '0;
    repeat (5) @(posedge tx_clock);
    #1;
    rst_n = 1'b1;
    test_idle();
    test_arp_reply();
    test_udp_fixed();
    test_udp_random();
    test_arp_and_udp();
    $display("** PASS **");
    $finish;
  end

endmodule

//--- logic/net_tx_top.sv
/* ethernet transmit top level
   arp reply and udp/ipv4 sources feeding the frame multiplexer */

`timescale 1ns/1ps

module net_tx_top
  import net_pkg::*;
(
  input  logic      tx_clock,
  input  logic      rst_n,
  // local addresses
  input  mac_addr_t local_mac,
  input  ip_addr_t  local_ip,
  // arp query from the receive side
  input  logic      arp_query,
  input  mac_addr_t query_mac,
  input  ip_addr_t  query_ip,
  // udp request
  input  logic      udp_tx_request,
  input  pay_len_t  udp_tx_length,
  input  mac_addr_t udp_dest_mac,
  input  ip_addr_t  udp_dest_ip,
  input  udp_port_t udp_dest_port,
  // udp payload
  input  byte_t     udp_tx_data,
  output logic      udp_tx_enable,
  // frame output
  output logic      frame_valid,
  output byte_t     frame_data
);

  tx_source_if arp_src ();
  tx_source_if udp_src ();

  // ------------------------------
  // frame sources
  // ------------------------------
  arp_reply_builder arp_i (
    .tx_clock  (tx_clock),
    .rst_n     (rst_n),
    .arp_query (arp_query),
    .query_mac (query_mac),
    .query_ip  (query_ip),
    .local_mac (local_mac),
    .local_ip  (local_ip),
    .src       (arp_src.source)
  );

  udp_ip_builder udp_i (
    .tx_clock       (tx_clock),
    .rst_n          (rst_n),
    .udp_tx_request (udp_tx_request),
    .udp_tx_length  (udp_tx_length),
    .udp_dest_mac   (udp_dest_mac),
    .udp_dest_ip    (udp_dest_ip),
    .udp_dest_port  (udp_dest_port),
    .local_ip       (local_ip),
    .udp_tx_data    (udp_tx_data),
    .udp_tx_enable  (udp_tx_enable),
    .src            (udp_src.source)
  );

  // ------------------------------
  // ethernet framing
  // ------------------------------
  frame_mux mux_i (
    .tx_clock    (tx_clock),
    .rst_n       (rst_n),
    .local_mac   (local_mac),
    .arp_src     (arp_src.mux),
    .udp_src     (udp_src.mux),
    .frame_valid (frame_valid),
    .frame_data  (frame_data)
  );

endmodule

//--- logic/frame_mux.sv
/* frame multiplexer
   arbitrates arp and udp, adds the ethernet header, forwards the body */

`timescale 1ns/1ps

module frame_mux
  import net_pkg::*;
(
  input  logic      tx_clock,
  input  logic      rst_n,
  input  mac_addr_t local_mac,
  tx_source_if.mux  arp_src,
  tx_source_if.mux  udp_src,
  output logic      frame_valid,
  output byte_t     frame_data
);

  typedef enum logic [1:0] {
    M_IDLE,
    M_HEADER,
    M_BODY
  } mux_state_t;

  mux_state_t   state;
  logic         sel_arp;
  logic [3:0]   hdr_cnt;
  logic         hdr_last;
  mac_addr_t    sel_mac;
  logic [15:0]  sel_type;
  logic [111:0] hdr_sh;
  logic         src_active;
  byte_t        src_data;

  // ------------------------------
  // selected source
  // ------------------------------
  assign sel_mac    = sel_arp ? arp_src.dest_mac : udp_src.dest_mac;
  assign sel_type   = sel_arp ? ETHERTYPE_ARP : ETHERTYPE_IPV4;
  assign src_active = sel_arp ? arp_src.active : udp_src.active;
  assign src_data   = sel_arp ? arp_src.data : udp_src.data;

  // header byte at hdr_cnt moved to the top
  assign hdr_sh   = {sel_mac, local_mac, sel_type} << {hdr_cnt, 3'b000};
  assign hdr_last = (hdr_cnt == 4'(ETH_HDR_LEN - 16'd1));

  // grant while the last header byte is loaded
  // so the first source byte follows it directly
  assign arp_src.enable = (state == M_HEADER) && hdr_last && sel_arp;
  assign udp_src.enable = (state == M_HEADER) && hdr_last && !sel_arp;

  // ------------------------------
  // state machine
  // ------------------------------
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      state       <= M_IDLE;
      sel_arp     <= 1'b0;
      hdr_cnt     <= 4'd0;
      frame_valid <= 1'b0;
    end else begin
      case (state)
        M_IDLE: begin
          frame_valid <= 1'b0;
          // arp wins a tie
          if (arp_src.request || udp_src.request) begin
            sel_arp <= arp_src.request;
            hdr_cnt <= 4'd0;
            state   <= M_HEADER;
          end
        end
        M_HEADER: begin
          frame_valid <= 1'b1;
          hdr_cnt     <= hdr_cnt + 4'd1;
          if (hdr_last) begin
            state <= M_BODY;
          end
        end
        M_BODY: begin
          // frame ends when the source drops active
          frame_valid <= src_active;
          if (!src_active) begin
            state <= M_IDLE;
          end
        end
        default:
          state <= M_IDLE;
      endcase
    end
  end

  // output byte register
  always_ff @(posedge tx_clock) begin
    frame_data <= (state == M_BODY) ? src_data : hdr_sh[111:104];
  end

endmodule

//--- logic/udp_ip_builder.sv
/* udp/ipv4 builder
   header checksum, ipv4 and udp headers, then the user payload */

`timescale 1ns/1ps

module udp_ip_builder
  import net_pkg::*;
(
  input  logic      tx_clock,
  input  logic      rst_n,
  input  logic      udp_tx_request,
  input  pay_len_t  udp_tx_length,
  input  mac_addr_t udp_dest_mac,
  input  ip_addr_t  udp_dest_ip,
  input  udp_port_t udp_dest_port,
  input  ip_addr_t  local_ip,
  input  byte_t     udp_tx_data,
  output logic      udp_tx_enable,
  tx_source_if.source src
);

  typedef enum logic [1:0] {
    U_IDLE,
    U_CSUM,
    U_REQ,
    U_SEND
  } udp_state_t;

  udp_state_t   state;
  logic [16:0]  cnt;
  logic [16:0]  send_last;
  pay_len_t     len;
  mac_addr_t    dmac;
  ip_addr_t     dip;
  ip_addr_t     lip;
  udp_port_t    dport;
  logic [15:0]  csum;
  pay_len_t     total_len;
  pay_len_t     udp_len;
  logic [223:0] hdr_sh;

  // inverted ones complement sum of the ipv4 header words
  // id, flags/fragment and the checksum word are zero
  function automatic logic [15:0] ip_checksum(input pay_len_t tot, input ip_addr_t sa,
                                              input ip_addr_t da);
    logic [19:0] acc;
    acc = {4'h0, IP_VER_IHL, 8'h00} + {4'h0, tot} + {4'h0, IP_TTL, IP_PROTO_UDP}
        + {4'h0, sa[31:16]} + {4'h0, sa[15:0]} + {4'h0, da[31:16]} + {4'h0, da[15:0]};
    // fold carries back twice
    acc = {4'h0, acc[15:0]} + {16'h0, acc[19:16]};
    acc = {4'h0, acc[15:0]} + {16'h0, acc[19:16]};
    return ~acc[15:0];
  endfunction

  assign total_len = len + IP_HDR_LEN + UDP_HDR_LEN;
  assign udp_len   = len + UDP_HDR_LEN;
  // 28 header bytes ahead of the payload
  assign send_last = {1'b0, len} + 17'(IP_HDR_LEN + UDP_HDR_LEN) - 17'd1;

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      state <= U_IDLE;
      cnt   <= 17'd0;
    end else begin
      case (state)
        U_IDLE:
          if (udp_tx_request) begin
            state <= U_CSUM;
          end
        U_CSUM:
          state <= U_REQ;
        U_REQ:
          if (src.enable) begin
            state <= U_SEND;
            cnt   <= 17'd0;
          end
        U_SEND: begin
          cnt <= cnt + 17'd1;
          if (cnt == send_last) begin
            state <= U_IDLE;
          end
        end
        default:
          state <= U_IDLE;
      endcase
    end
  end

  // request fields and the checksum one cycle later
  always_ff @(posedge tx_clock) begin
    if (state == U_IDLE && udp_tx_request) begin
      len   <= udp_tx_length;
      dmac  <= udp_dest_mac;
      dip   <= udp_dest_ip;
      dport <= udp_dest_port;
      lip   <= local_ip;
    end
    if (state == U_CSUM) begin
      csum <= ip_checksum(total_len, lip, dip);
    end
  end

  // ------------------------------
  // byte stream
  // ------------------------------
  // ipv4 header then udp header with a zero udp checksum
  assign hdr_sh = {IP_VER_IHL, 8'h00, total_len, 16'h0000, 16'h0000,
                   IP_TTL, IP_PROTO_UDP, csum, lip, dip,
                   LOCAL_UDP_PORT, dport, udp_len, 16'h0000} << {cnt[4:0], 3'b000};

  // user sees this on the last header byte so the payload follows directly
  assign udp_tx_enable = (state == U_SEND) &&
                         (cnt == 17'(IP_HDR_LEN + UDP_HDR_LEN - 16'd1));

  assign src.request  = (state == U_REQ);
  assign src.active   = (state == U_SEND);
  assign src.data     = (cnt < 17'(IP_HDR_LEN + UDP_HDR_LEN)) ? hdr_sh[223:216] : udp_tx_data;
  assign src.dest_mac = dmac;

endmodule

//--- logic/arp_reply_builder.sv
/* arp reply builder
   latches one query and streams the 28-byte reply body */

`timescale 1ns/1ps

module arp_reply_builder
  import net_pkg::*;
(
  input  logic      tx_clock,
  input  logic      rst_n,
  input  logic      arp_query,
  input  mac_addr_t query_mac,
  input  ip_addr_t  query_ip,
  input  mac_addr_t local_mac,
  input  ip_addr_t  local_ip,
  tx_source_if.source src
);

  logic       pending;
  logic       active;
  logic [4:0] cnt;
  logic       take_query;
  mac_addr_t  q_mac;
  ip_addr_t   q_ip;
  logic [223:0] body_sh;

  // queries are taken only while no reply is granted or running
  assign take_query = arp_query && !active && !src.enable;

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
      active  <= 1'b0;
      cnt     <= 5'd0;
    end else begin
      if (src.enable) begin
        // grant seen, start streaming next cycle
        pending <= 1'b0;
        active  <= 1'b1;
        cnt     <= 5'd0;
      end else if (active) begin
        cnt <= cnt + 5'd1;
        if (cnt == 5'(ARP_BODY_LEN - 16'd1)) begin
          active <= 1'b0;
        end
      end
      // later query before service just overwrites
      if (take_query) begin
        pending <= 1'b1;
      end
    end
  end

  // querier addresses
  always_ff @(posedge tx_clock) begin
    if (take_query) begin
      q_mac <= query_mac;
      q_ip  <= query_ip;
    end
  end

  // ------------------------------
  // reply body, big endian
  // ------------------------------
  // current byte shifted to the top
  assign body_sh = {ARP_HTYPE_ETH, ETHERTYPE_IPV4, ARP_HLEN, ARP_PLEN, ARP_OPER_REPLY,
                    local_mac, local_ip, q_mac, q_ip} << {cnt, 3'b000};

  assign src.request  = pending;
  assign src.active   = active;
  assign src.data     = body_sh[223:216];
  assign src.dest_mac = q_mac;

endmodule

//--- logic/tx_source_if.sv
/* link between one frame source and the frame multiplexer */

`timescale 1ns/1ps

interface tx_source_if
  import net_pkg::*;
();

  // source has a frame waiting
  logic      request;
  // one-cycle grant from the mux
  logic      enable;
  // high while the source streams bytes
  logic      active;
  byte_t     data;
  // ethernet destination for the waiting frame
  mac_addr_t dest_mac;

  modport source (
    output request,
    output active,
    output data,
    output dest_mac,
    input  enable
  );

  modport mux (
    input  request,
    input  active,
    input  data,
    input  dest_mac,
    output enable
  );

endinterface

//--- logic/net_pkg.sv
/* network types, protocol constants and header lengths
   shared by the transmit path */

package net_pkg;

  // ------------------------------
  // field types
  // ------------------------------
  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] pay_len_t;

  // ------------------------------
  // ethertypes
  // ------------------------------
  localparam logic [15:0] ETHERTYPE_ARP  = 16'h0806;
  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;

  // ------------------------------
  // header lengths in bytes
  // ------------------------------
  localparam pay_len_t ETH_HDR_LEN  = 16'd14;
  localparam pay_len_t IP_HDR_LEN   = 16'd20;
  localparam pay_len_t UDP_HDR_LEN  = 16'd8;
  localparam pay_len_t ARP_BODY_LEN = 16'd28;

  // ------------------------------
  // ipv4 / udp fields
  // ------------------------------
  // version 4, five header words
  localparam byte_t     IP_VER_IHL     = 8'h45;
  localparam byte_t     IP_TTL         = 8'd128;
  localparam byte_t     IP_PROTO_UDP   = 8'd17;
  localparam udp_port_t LOCAL_UDP_PORT = 16'd1024;

  // ------------------------------
  // arp fields
  // ------------------------------
  // ethernet hardware type
  localparam logic [15:0] ARP_HTYPE_ETH  = 16'h0001;
  localparam byte_t       ARP_HLEN       = 8'd6;
  localparam byte_t       ARP_PLEN       = 8'd4;
  localparam logic [15:0] ARP_OPER_REPLY = 16'd2;

endpackage
